// ==== Makefile ====
TOP = tb_dec_arf

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

obj_dir/V$(TOP): flist.f hw/*.sv hw/*.svh test/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "failure reported in sim.log"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
+incdir+hw
hw/dec_rf_pkg.sv
hw/dec_trace_pkg.sv
hw/dec_nbload_track.sv
hw/dec_gpr_file.sv
hw/dec_trace_out.sv
hw/dec_arf_top.sv
test/tb_dec_arf.sv

// ==== hw/dec_arf_top.sv ====
`timescale 1ns/1ns

module dec_arf_top
   import dec_rf_pkg::*;
   import dec_trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // operand reads
   input  rf_rd_req_t  rd_i0_rs1,
   input  rf_rd_req_t  rd_i0_rs2,
   input  rf_rd_req_t  rd_i1_rs1,
   input  rf_rd_req_t  rd_i1_rs2,
   // writebacks
   input  rf_wr_t      wb_i0,
   input  rf_wr_t      wb_i1,
   // lsu non-blocking loads
   input  logic        nbload_valid,
   input  nbload_tag_t nbload_tag,
   input  reg_addr_t   nbload_rd,
   input  logic        nbload_inv,
   input  nbload_tag_t nbload_inv_tag,
   input  logic        nbload_data_valid,
   input  logic        nbload_data_error,
   input  nbload_tag_t nbload_data_tag,
   input  xlen_t       nbload_data,
   // retire
   input  retire_grp_t retire,
   output xlen_t       rd_i0_rs1_data,
   output xlen_t       rd_i0_rs2_data,
   output xlen_t       rd_i1_rs1_data,
   output xlen_t       rd_i1_rs2_data,
   output trace_pkt_t  trace_pkt
);

   rf_wr_t nbload_wr; // tracker to gpr file

   dec_nbload_track u_nbload (
      .clk               (clk),
      .rst               (rst),
      .nbload_valid      (nbload_valid),
      .nbload_tag        (nbload_tag),
      .nbload_rd         (nbload_rd),
      .nbload_inv        (nbload_inv),
      .nbload_inv_tag    (nbload_inv_tag),
      .nbload_data_valid (nbload_data_valid),
      .nbload_data_error (nbload_data_error),
      .nbload_data_tag   (nbload_data_tag),
      .nbload_data       (nbload_data),
      .nbload_wr         (nbload_wr)
   );

   dec_gpr_file u_gpr (
      .clk            (clk),
      .rst            (rst),
      .rd_i0_rs1      (rd_i0_rs1),
      .rd_i0_rs2      (rd_i0_rs2),
      .rd_i1_rs1      (rd_i1_rs1),
      .rd_i1_rs2      (rd_i1_rs2),
      .wb_i0          (wb_i0),
      .wb_i1          (wb_i1),
      .nbload_wr      (nbload_wr),
      .rd_i0_rs1_data (rd_i0_rs1_data),
      .rd_i0_rs2_data (rd_i0_rs2_data),
      .rd_i1_rs1_data (rd_i1_rs1_data),
      .rd_i1_rs2_data (rd_i1_rs2_data)
   );

   dec_trace_out u_trace (
      .clk       (clk),
      .rst       (rst),
      .retire    (retire),
      .trace_pkt (trace_pkt)
   );

endmodule

// ==== hw/dec_gpr_file.sv ====
`timescale 1ns/1ns

module dec_gpr_file
   import dec_rf_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  rf_rd_req_t rd_i0_rs1,      // slot 0 operands
   input  rf_rd_req_t rd_i0_rs2,
   input  rf_rd_req_t rd_i1_rs1,      // slot 1 operands
   input  rf_rd_req_t rd_i1_rs2,
   input  rf_wr_t     wb_i0,          // lowest priority
   input  rf_wr_t     wb_i1,
   input  rf_wr_t     nbload_wr,      // highest priority
   output xlen_t      rd_i0_rs1_data,
   output xlen_t      rd_i0_rs2_data,
   output xlen_t      rd_i1_rs1_data,
   output xlen_t      rd_i1_rs2_data
);

   localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

   xlen_t gpr_q [1:NUM_REGS-1]; // x0 has no storage

   // disabled read or x0 gives zero, no write bypass
   function automatic xlen_t rd_port(rf_rd_req_t req);
      xlen_t data;
      data = '0;
      if (req.rden && (req.raddr != '0))
         data = gpr_q[req.raddr];
      return data;
   endfunction

   // ************************************************************
   // write ports
   // ************************************************************

   // later statement wins, so order is the priority
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < NUM_REGS; i++)
            gpr_q[i] <= '0;
      end else begin
         if (wb_i0.wen && (wb_i0.waddr != '0))
            gpr_q[wb_i0.waddr] <= wb_i0.wdata;
         if (wb_i1.wen && (wb_i1.waddr != '0))
            gpr_q[wb_i1.waddr] <= wb_i1.wdata;
         if (nbload_wr.wen && (nbload_wr.waddr != '0))
            gpr_q[nbload_wr.waddr] <= nbload_wr.wdata; // load return
      end
   end

   // ************************************************************
   // read ports
   // ************************************************************

   always_comb begin
      rd_i0_rs1_data = rd_port(rd_i0_rs1);
      rd_i0_rs2_data = rd_port(rd_i0_rs2);
      rd_i1_rs1_data = rd_port(rd_i1_rs1);
      rd_i1_rs2_data = rd_port(rd_i1_rs2);
   end

   // x0 stays zero on every port, whatever was written before
   a_x0_zero : assert property (@(posedge clk) disable iff (rst)
      ((rd_i0_rs1.raddr == '0) -> (rd_i0_rs1_data == '0)) &&
      ((rd_i0_rs2.raddr == '0) -> (rd_i0_rs2_data == '0)) &&
      ((rd_i1_rs1.raddr == '0) -> (rd_i1_rs1_data == '0)) &&
      ((rd_i1_rs2.raddr == '0) -> (rd_i1_rs2_data == '0)))
      else $error("x0 read returned nonzero data");

endmodule

// ==== hw/dec_nbload_track.sv ====
`timescale 1ns/1ns
`include "dec_settings.svh"

module dec_nbload_track
   import dec_rf_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        nbload_valid,      // allocate a tag
   input  nbload_tag_t nbload_tag,
   input  reg_addr_t   nbload_rd,         // destination for the load
   input  logic        nbload_inv,        // load squashed, drop its data
   input  nbload_tag_t nbload_inv_tag,
   input  logic        nbload_data_valid, // data coming back from lsu
   input  logic        nbload_data_error, // bus error on the return
   input  nbload_tag_t nbload_data_tag,
   input  xlen_t       nbload_data,
   output rf_wr_t      nbload_wr          // load write port into gpr file
);

   localparam int TAGS = `DEC_NBLOAD_TAGS;

   logic [TAGS-1:0] tag_vld_q;       // load outstanding on this tag
   reg_addr_t       tag_rd_q [TAGS]; // recorded destination per tag
   logic [TAGS-1:0] tag_set;
   logic [TAGS-1:0] tag_clr;
   logic            ret_hit;         // return matches a live tag

   assign ret_hit = nbload_data_valid & tag_vld_q[nbload_data_tag];

   // ************************************************************
   // tag table
   // ************************************************************

   always_comb begin
      tag_set = '0;
      tag_clr = '0;
      if (nbload_valid)
         tag_set[nbload_tag] = 1'b1;
      if (nbload_inv)
         tag_clr[nbload_inv_tag] = 1'b1;  // squash
      if (ret_hit)
         tag_clr[nbload_data_tag] = 1'b1; // freed on return, error or not
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         tag_vld_q <= '0;
      end else begin
         tag_vld_q <= (tag_vld_q & ~tag_clr) | tag_set; // alloc beats free
      end
   end

   always_ff @(posedge clk) begin
      if (nbload_valid) begin
         tag_rd_q[nbload_tag] <= nbload_rd;
      end
   end

   // returning data goes straight to the recorded rd
   always_comb begin
      nbload_wr.wen   = ret_hit & ~nbload_data_error; // error drops the data
      nbload_wr.waddr = tag_rd_q[nbload_data_tag];
      nbload_wr.wdata = nbload_data;
   end

   // ************************************************************
   // lsu tag usage checks
   // ************************************************************

   a_alloc_free_tag : assert property (@(posedge clk) disable iff (rst)
      nbload_valid |-> (!tag_vld_q[nbload_tag] || tag_clr[nbload_tag]))
      else $error("nbload alloc to busy tag %0d", nbload_tag);

   a_alloc_vs_return : assert property (@(posedge clk) disable iff (rst)
      (nbload_valid && nbload_data_valid) |-> (nbload_tag != nbload_data_tag))
      else $error("nbload alloc and return on tag %0d", nbload_tag);

endmodule

// ==== hw/dec_rf_pkg.sv ====
`include "dec_settings.svh"

package dec_rf_pkg;

   // ************************************************************
   // register file word and index types
   // ************************************************************

   typedef logic [`DEC_XLEN-1:0]              xlen_t;       // one gpr word
   typedef logic [$clog2(`DEC_NUM_REGS)-1:0]  reg_addr_t;   // gpr index
   typedef logic [`DEC_NBLOAD_TAG_W-1:0]      nbload_tag_t; // lsu load tag

   // one write port, 38 bits
   typedef struct packed {
      logic      wen;   // write strobe
      reg_addr_t waddr; // destination gpr
      xlen_t     wdata; // value to write
   } rf_wr_t;

   // one read request, 6 bits
   typedef struct packed {
      logic      rden;  // operand used, else data forced to zero
      reg_addr_t raddr; // source gpr
   } rf_rd_req_t;

endpackage

// ==== hw/dec_settings.svh ====
`ifndef DEC_SETTINGS_SVH
`define DEC_SETTINGS_SVH

// ************************************************************
// datapath and register file sizing
// ************************************************************

`define DEC_XLEN          32 // integer data word width
`define DEC_NUM_REGS      32 // x0..x31, x0 hardwired to zero

// ************************************************************
// non-blocking load tracking
// ************************************************************

`define DEC_NBLOAD_TAGS   4  // loads in flight at once
`define DEC_NBLOAD_TAG_W  2  // must cover DEC_NBLOAD_TAGS

`endif

// ==== hw/dec_trace_out.sv ====
`timescale 1ns/1ns

module dec_trace_out
   import dec_trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  retire_grp_t retire,   // retire info for this cycle
   output trace_pkt_t  trace_pkt // same info, one cycle later
);

   logic [1:0] slot_ret_q; // normal retire per slot
   logic [1:0] slot_exc_q; // exception per slot
   logic       int_vld_q;
   insn_t      i0_insn_q;
   insn_t      i1_insn_q;
   pc_t        i0_pc_q;
   pc_t        i1_pc_q;
   ecause_t    ecause_q;
   tval_t      tval_q;

   // ************************************************************
   // retire capture
   // ************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         slot_ret_q <= '0;
         slot_exc_q <= '0;
         int_vld_q  <= 1'b0;
      end else begin
         slot_ret_q <= {retire.slot1.valid, retire.slot0.valid};
         slot_exc_q <= {retire.slot1.exc_valid, retire.slot0.exc_valid};
         int_vld_q  <= retire.int_valid;
      end
   end

   always_ff @(posedge clk) begin
      i0_insn_q <= retire.slot0.instr;
      i1_insn_q <= retire.slot1.instr;
      i0_pc_q   <= retire.slot0.pc;
      i1_pc_q   <= retire.slot1.pc;
      ecause_q  <= retire.exc_cause;
      tval_q    <= retire.mtval;
   end

   // ************************************************************
   // packet build
   // ************************************************************

   always_comb begin
      trace_pkt.insn      = {insn_t'(0), i1_insn_q, i0_insn_q}; // port 2 unused
      trace_pkt.address   = {insn_t'(0), i1_pc_q, 1'b0, i0_pc_q, 1'b0};
      trace_pkt.valid     = {int_vld_q, slot_ret_q | slot_exc_q};
      trace_pkt.exception = {int_vld_q, slot_exc_q};
      trace_pkt.ecause    = ecause_q; // one cause for both slots
      trace_pkt.interrupt = {int_vld_q, 2'b00};
      trace_pkt.tval      = tval_q;   // likewise shared
   end

endmodule

// ==== hw/dec_trace_pkg.sv ====
`include "dec_settings.svh"

package dec_trace_pkg;

   localparam int TRACE_PORTS = 3; // slot0, slot1, interrupt port

   typedef logic [`DEC_XLEN-1:0] insn_t;   // retired instruction word
   typedef logic [`DEC_XLEN-1:1] pc_t;     // halfword aligned pc
   typedef logic [4:0]           ecause_t; // mcause code
   typedef logic [`DEC_XLEN-1:0] tval_t;   // mtval value

   // ************************************************************
   // retire side, one entry per issue slot
   // ************************************************************

   typedef struct packed {
      logic  valid;     // slot retired normally
      logic  exc_valid; // slot took an exception
      insn_t instr;
      pc_t   pc;
   } retire_slot_t;

   typedef struct packed {
      retire_slot_t slot1;
      retire_slot_t slot0;
      logic         int_valid; // interrupt taken this cycle
      ecause_t      exc_cause; // shared by both slots
      tval_t        mtval;     // shared by both slots
   } retire_grp_t;

   // trace port packet, port 2 carries interrupts only
   typedef struct packed {
      logic [TRACE_PORTS*`DEC_XLEN-1:0] insn;
      logic [TRACE_PORTS*`DEC_XLEN-1:0] address;
      logic [TRACE_PORTS-1:0]           valid;
      logic [TRACE_PORTS-1:0]           exception;
      ecause_t                          ecause;
      logic [TRACE_PORTS-1:0]           interrupt;
      tval_t                            tval;
   } trace_pkt_t;

endpackage

// ==== test/tb_dec_arf.sv ====
`timescale 1ns/1ns
`include "dec_settings.svh"

module tb_dec_arf
   import dec_rf_pkg::*;
   import dec_trace_pkg::*;
();

   localparam int TAGS      = `DEC_NBLOAD_TAGS;
   localparam int NUM_REGS  = `DEC_NUM_REGS;
   localparam int RAND_CYCS = 3000;         // random phase length
   localparam int DRAIN_MAX = 40;           // cycles allowed to empty the tag table

   logic        clk;
   logic        rst;
   rf_rd_req_t  rd_i0_rs1;
   rf_rd_req_t  rd_i0_rs2;
   rf_rd_req_t  rd_i1_rs1;
   rf_rd_req_t  rd_i1_rs2;
   rf_wr_t      wb_i0;
   rf_wr_t      wb_i1;
   logic        nbload_valid;
   nbload_tag_t nbload_tag;
   reg_addr_t   nbload_rd;
   logic        nbload_inv;
   nbload_tag_t nbload_inv_tag;
   logic        nbload_data_valid;
   logic        nbload_data_error;
   nbload_tag_t nbload_data_tag;
   xlen_t       nbload_data;
   retire_grp_t retire;
   xlen_t       rd_i0_rs1_data;
   xlen_t       rd_i0_rs2_data;
   xlen_t       rd_i1_rs1_data;
   xlen_t       rd_i1_rs2_data;
   trace_pkt_t  trace_pkt;

   xlen_t       model_regs [NUM_REGS];   // expected gpr contents
   logic        model_tag_vld [TAGS];    // expected outstanding loads
   reg_addr_t   model_tag_rd [TAGS];
   retire_grp_t prev_ret;                // group the trace packet should show
   logic [31:0] lfsr_state;
   int          check_cnt;
   int          error_cnt;
   int          drain_cnt;
   logic        busy;

   dec_arf_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ************************************************************
   // random source and stimulus builders
   // ************************************************************

   // one galois step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hb4bcd35c) : (lfsr_state >> 1);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic reg_addr_t pick_addr();
      if (lfsr_bits(1) != 0)
         return reg_addr_t'(lfsr_bits(3)); // x0..x7, makes same-reg collisions common
      return reg_addr_t'(lfsr_bits(5));
   endfunction

   function automatic rf_rd_req_t make_read();
      rf_rd_req_t r;
      r.rden  = (lfsr_bits(2) != 0); // mostly enabled
      r.raddr = pick_addr();
      return r;
   endfunction

   function automatic rf_wr_t make_write();
      rf_wr_t w;
      w.wen   = (lfsr_bits(2) != 0);
      w.waddr = pick_addr();
      w.wdata = lfsr_bits(32);
      return w;
   endfunction

   function automatic retire_slot_t make_slot();
      retire_slot_t s;
      s.valid     = 1'(lfsr_bits(1));
      s.exc_valid = (lfsr_bits(3) == 0); // rare
      s.instr     = lfsr_bits(32);
      s.pc        = pc_t'(lfsr_bits(31));
      return s;
   endfunction

   // ************************************************************
   // reference rules
   // ************************************************************

   function automatic xlen_t expect_read(rf_rd_req_t req);
      if (!req.rden || req.raddr == '0)
         return '0;
      return model_regs[req.raddr];
   endfunction

   function automatic trace_pkt_t expect_trace(retire_grp_t r);
      trace_pkt_t t;
      t.insn      = {32'h0, r.slot1.instr, r.slot0.instr};        // third port unused
      t.address   = {32'h0, r.slot1.pc, 1'b0, r.slot0.pc, 1'b0};
      t.valid     = {r.int_valid, r.slot1.valid | r.slot1.exc_valid,
                     r.slot0.valid | r.slot0.exc_valid};
      t.exception = {r.int_valid, r.slot1.exc_valid, r.slot0.exc_valid};
      t.ecause    = r.exc_cause;
      t.interrupt = {r.int_valid, 2'b00};
      t.tval      = r.mtval;
      return t;
   endfunction

   task automatic check_val(input string name, input logic [95:0] exp, input logic [95:0] act);
      check_cnt++;
      assert (act === exp)
      else begin
         $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
         error_cnt++;
      end
   endtask

   task automatic drive_idle();
      rd_i0_rs1         = '0;
      rd_i0_rs2         = '0;
      rd_i1_rs1         = '0;
      rd_i1_rs2         = '0;
      wb_i0             = '0;
      wb_i1             = '0;
      nbload_valid      = 1'b0;
      nbload_tag        = '0;
      nbload_rd         = '0;
      nbload_inv        = 1'b0;
      nbload_inv_tag    = '0;
      nbload_data_valid = 1'b0;
      nbload_data_error = 1'b0;
      nbload_data_tag   = '0;
      nbload_data       = '0;
      retire            = '0;
   endtask

   // mode 0 reads only, 1 full random, 2 return outstanding loads
   task automatic drive_stimulus(input int mode);
      nbload_tag_t t;
      drive_idle();
      rd_i0_rs1 = make_read();
      rd_i0_rs2 = make_read();
      rd_i1_rs1 = make_read();
      rd_i1_rs2 = make_read();
      if (mode == 1) begin
         wb_i0             = make_write();
         wb_i1             = make_write();
         nbload_data_valid = 1'(lfsr_bits(1));
         nbload_data_tag   = nbload_tag_t'(lfsr_bits(2)); // may hit a dead tag
         nbload_data_error = (lfsr_bits(3) == 0);
         nbload_data       = lfsr_bits(32);
         nbload_inv        = (lfsr_bits(3) == 0);
         nbload_inv_tag    = nbload_tag_t'(lfsr_bits(2));
         t                 = nbload_tag_t'(lfsr_bits(2));
         // free tags only, never the one returning now
         nbload_valid = (lfsr_bits(1) != 0) && !model_tag_vld[t] &&
                        !(nbload_data_valid && (t == nbload_data_tag));
         nbload_tag   = t;
         nbload_rd    = pick_addr();
         retire.slot0     = make_slot();
         retire.slot1     = make_slot();
         retire.int_valid = (lfsr_bits(3) == 0);
         retire.exc_cause = ecause_t'(lfsr_bits(5));
         retire.mtval     = lfsr_bits(32);
      end else if (mode == 2) begin
         for (int k = TAGS - 1; k >= 0; k--) begin
            if (model_tag_vld[k]) begin
               nbload_data_valid = 1'b1;           // lowest busy tag ends up chosen
               nbload_data_tag   = nbload_tag_t'(k);
            end
         end
         nbload_data_error = (lfsr_bits(3) == 0);
         nbload_data       = lfsr_bits(32);
      end
   endtask

   task automatic check_outputs();
      trace_pkt_t exp_t;
      exp_t = expect_trace(prev_ret);
      check_val("rd_i0_rs1_data", 96'(expect_read(rd_i0_rs1)), 96'(rd_i0_rs1_data));
      check_val("rd_i0_rs2_data", 96'(expect_read(rd_i0_rs2)), 96'(rd_i0_rs2_data));
      check_val("rd_i1_rs1_data", 96'(expect_read(rd_i1_rs1)), 96'(rd_i1_rs1_data));
      check_val("rd_i1_rs2_data", 96'(expect_read(rd_i1_rs2)), 96'(rd_i1_rs2_data));
      check_val("trace_pkt.insn", exp_t.insn, trace_pkt.insn);
      check_val("trace_pkt.address", exp_t.address, trace_pkt.address);
      check_val("trace_pkt.valid", 96'(exp_t.valid), 96'(trace_pkt.valid));
      check_val("trace_pkt.exception", 96'(exp_t.exception), 96'(trace_pkt.exception));
      check_val("trace_pkt.ecause", 96'(exp_t.ecause), 96'(trace_pkt.ecause));
      check_val("trace_pkt.interrupt", 96'(exp_t.interrupt), 96'(trace_pkt.interrupt));
      check_val("trace_pkt.tval", 96'(exp_t.tval), 96'(trace_pkt.tval));
   endtask

   // rising edge view of the inputs driven at the last falling edge
   task automatic update_model();
      logic      ld_hit;
      reg_addr_t ld_rd;
      ld_hit = nbload_data_valid && model_tag_vld[nbload_data_tag];
      ld_rd  = model_tag_rd[nbload_data_tag];
      if (wb_i0.wen && wb_i0.waddr != '0)
         model_regs[wb_i0.waddr] = wb_i0.wdata;
      if (wb_i1.wen && wb_i1.waddr != '0)
         model_regs[wb_i1.waddr] = wb_i1.wdata; // slot 1 over slot 0
      if (ld_hit && !nbload_data_error && ld_rd != '0)
         model_regs[ld_rd] = nbload_data;        // load return over both
      if (nbload_inv)
         model_tag_vld[nbload_inv_tag] = 1'b0;
      if (ld_hit)
         model_tag_vld[nbload_data_tag] = 1'b0;
      if (nbload_valid) begin
         model_tag_vld[nbload_tag] = 1'b1;        // allocation wins a same-tag free
         model_tag_rd[nbload_tag]  = nbload_rd;
      end
      prev_ret = retire;
   endtask

   task automatic run_cycle(input int mode);
      @(negedge clk);
      drive_stimulus(mode);
      #1;
      check_outputs();
      @(posedge clk);
      update_model();
   endtask

   function automatic logic any_busy();
      logic b;
      b = 1'b0;
      for (int k = 0; k < TAGS; k++)
         b = b | model_tag_vld[k];
      return b;
   endfunction

   // ************************************************************
   // test sequence
   // ************************************************************

   initial begin
      lfsr_state = 32'ha93b7ec2;
      check_cnt  = 0;
      error_cnt  = 0;
      drive_idle();
      rst = 1'b1;
      for (int i = 0; i < NUM_REGS; i++)
         model_regs[i] = '0;
      for (int k = 0; k < TAGS; k++) begin
         model_tag_vld[k] = 1'b0;
         model_tag_rd[k]  = '0;
      end
      prev_ret = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      repeat (4) run_cycle(0);          // reset values on random reads
      repeat (RAND_CYCS) run_cycle(1);

      // return whatever is still in flight
      drain_cnt = 0;
      busy      = any_busy();
      while (busy && drain_cnt < DRAIN_MAX) begin
         run_cycle(2);
         drain_cnt++;
         busy = any_busy();
      end
      if (busy) begin
         $display("error: loads still outstanding after %0d drain cycles", drain_cnt);
         error_cnt++;
      end
      repeat (4) run_cycle(0);

      $display("checks %0d  errors %0d", check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule
